//--- include/wb_accel_macros.svh
// accumulator accelerator constants
// address map, data width, stream counts and default queue depth

`ifndef WB_ACCEL_MACROS_SVH
`define WB_ACCEL_MACROS_SVH

////////////////////////////////////////////////////////////
// data path
////////////////////////////////////////////////////////////

// width of bus data and of every stream word
`define WB_DATA_W 32

////////////////////////////////////////////////////////////
// stream address map
////////////////////////////////////////////////////////////

// input stream 0 is commands, input stream 1 is operands
`define NUM_ISTREAM 2
// output stream 0 is results
`define NUM_OSTREAM 1

// each stream slot is 8 bytes: status at +0, data at +4
`define ISTREAM_BASE 32'h3000_0000
`define OSTREAM_BASE (`ISTREAM_BASE + 32'd8 * `NUM_ISTREAM)

////////////////////////////////////////////////////////////
// queues
////////////////////////////////////////////////////////////

`define QUEUE_DEPTH 4

`endif

//--- logic/accel_exec_stage.sv
// accelerator stage 2
// applies the opcode to the accumulator and registers the new value as a result

`timescale 1ns/100ps
`include "wb_accel_macros.svh"

module accel_exec_stage (
  input  logic                    clk,
  input  logic                    rst_n_i,
  // joined item from stage 1
  input  logic                    j_val_i,
  output logic                    j_rdy_o,
  input  wb_accel_pkg::accel_op_e j_op_i,
  input  logic [`WB_DATA_W-1:0]   j_opnd_i,
  // result stream
  output logic                    res_val_o,
  input  logic                    res_rdy_i,
  output logic [`WB_DATA_W-1:0]   res_data_o
);

  logic [`WB_DATA_W-1:0] acc;
  logic [`WB_DATA_W-1:0] acc_next;
  logic                  accept;

  // result register frees up when it is empty or the queue takes it
  assign j_rdy_o = !res_val_o || res_rdy_i;
  assign accept  = j_val_i && j_rdy_o;

  ////////////////////////////////////////////////////////////
  // accumulator update
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (j_op_i)
      wb_accel_pkg::OP_LOAD: acc_next = j_opnd_i;
      wb_accel_pkg::OP_ADD:  acc_next = acc + j_opnd_i;
      wb_accel_pkg::OP_XOR:  acc_next = acc ^ j_opnd_i;
      // low word of the product only
      wb_accel_pkg::OP_MUL:  acc_next = acc * j_opnd_i;
      default:               acc_next = acc;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      acc       <= '0;
      res_val_o <= 1'b0;
    end else if (accept) begin
      acc       <= acc_next;
      res_val_o <= 1'b1;
    end else if (res_rdy_i) begin
      res_val_o <= 1'b0;
    end
  end

  // result word toward the output queue
  always_ff @(posedge clk) begin
    if (accept) begin
      res_data_o <= acc_next;
    end
  end

endmodule

//--- logic/accel_join_stage.sv
// accelerator stage 1
// joins one command with one operand and registers opcode and operand

`timescale 1ns/100ps
`include "wb_accel_macros.svh"

module accel_join_stage (
  input  logic                    clk,
  input  logic                    rst_n_i,
  // command stream
  input  logic                    cmd_val_i,
  output logic                    cmd_rdy_o,
  input  logic [`WB_DATA_W-1:0]   cmd_data_i,
  // operand stream
  input  logic                    opnd_val_i,
  output logic                    opnd_rdy_o,
  input  logic [`WB_DATA_W-1:0]   opnd_data_i,
  // joined item toward exec stage
  output logic                    j_val_o,
  input  logic                    j_rdy_i,
  output wb_accel_pkg::accel_op_e j_op_o,
  output logic [`WB_DATA_W-1:0]   j_opnd_o
);

  logic                    both_val;
  logic                    can_accept;
  logic                    take;
  wb_accel_pkg::accel_op_e dec_op;

  // register is free when empty or draining this cycle
  assign both_val   = cmd_val_i && opnd_val_i;
  assign can_accept = !j_val_o || j_rdy_i;
  assign take       = both_val && can_accept;

  // both heads leave together or not at all
  assign cmd_rdy_o  = take;
  assign opnd_rdy_o = take;

  // opcode lives in the low two bits of the command word
  assign dec_op = wb_accel_pkg::accel_op_e'(cmd_data_i[1:0]);

  ////////////////////////////////////////////////////////////
  // pipeline register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      j_val_o <= 1'b0;
    end else if (take) begin
      j_val_o <= 1'b1;
    end else if (j_rdy_i) begin
      j_val_o <= 1'b0;
    end
  end

  // payload, held while stalled
  always_ff @(posedge clk) begin
    if (take) begin
      j_op_o   <= dec_op;
      j_opnd_o <= opnd_data_i;
    end
  end

endmodule

//--- logic/stream_queue.sv
// stream queue
// circular-buffer FIFO with valid/ready on both sides and a free-entry count

`timescale 1ns/100ps

module stream_queue #(
  parameter int DEPTH = 4,
  parameter int WIDTH = 32
) (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       enq_val_i,
  output logic                       enq_rdy_o,
  input  logic [WIDTH-1:0]           enq_data_i,
  output logic                       deq_val_o,
  input  logic                       deq_rdy_i,
  output logic [WIDTH-1:0]           deq_data_o,
  output logic [$clog2(DEPTH+1)-1:0] num_free_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_enq;
  logic             do_deq;

  // a full queue still takes a word when the head leaves this cycle
  assign deq_val_o  = (count != '0);
  assign enq_rdy_o  = (count != FULL_CNT) || deq_rdy_i;
  assign do_deq     = deq_val_o && deq_rdy_i;
  assign do_enq     = enq_val_i && enq_rdy_o;
  assign num_free_o = FULL_CNT - count;

  // head straight from storage
  assign deq_data_o = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_enq) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (do_deq) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_enq, do_deq})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (do_enq) begin
      mem[wr_ptr] <= enq_data_i;
    end
  end

endmodule

//--- logic/wb_accel_pkg.sv
// accumulator accelerator types
// bus access classification and accumulator opcodes

package wb_accel_pkg;

  // kind of bus access after address decode
  typedef enum logic [2:0] {
    ACC_NONE       = 3'd0,
    ACC_IN_STATUS  = 3'd1,
    ACC_IN_WRITE   = 3'd2,
    ACC_OUT_STATUS = 3'd3,
    ACC_OUT_READ   = 3'd4
  } wb_access_e;

  // accumulator opcode, taken from bits 1:0 of a command word
  typedef enum logic [1:0] {
    // acc = operand
    OP_LOAD = 2'd0,
    // acc = acc + operand, wraps at 32 bits
    OP_ADD  = 2'd1,
    // acc = acc ^ operand
    OP_XOR  = 2'd2,
    // acc = low 32 bits of acc * operand
    OP_MUL  = 2'd3
  } accel_op_e;

endpackage

//--- logic/wb_accel_top.sv
// accumulator accelerator top
// wishbone stream bridge feeding the join and exec pipeline stages

`timescale 1ns/100ps
`include "wb_accel_macros.svh"

module wb_accel_top (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  wbs_stb_i,
  input  logic                  wbs_cyc_i,
  input  logic                  wbs_we_i,
  input  logic [3:0]            wbs_sel_i,
  input  logic [31:0]           wbs_adr_i,
  input  logic [`WB_DATA_W-1:0] wbs_dat_i,
  output logic                  wbs_ack_o,
  output logic [`WB_DATA_W-1:0] wbs_dat_o
);

  // bridge to stage 1
  logic                    cmd_val;
  logic                    cmd_rdy;
  logic [`WB_DATA_W-1:0]   cmd_data;
  logic                    opnd_val;
  logic                    opnd_rdy;
  logic [`WB_DATA_W-1:0]   opnd_data;
  // stage 1 to stage 2
  logic                    j_val;
  logic                    j_rdy;
  wb_accel_pkg::accel_op_e j_op;
  logic [`WB_DATA_W-1:0]   j_opnd;
  // stage 2 to bridge
  logic                    res_val;
  logic                    res_rdy;
  logic [`WB_DATA_W-1:0]   res_data;

  wb_stream_bridge #(
    .DEPTH (`QUEUE_DEPTH)
  ) bridge_inst (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .wbs_stb_i   (wbs_stb_i),
    .wbs_cyc_i   (wbs_cyc_i),
    .wbs_we_i    (wbs_we_i),
    .wbs_sel_i   (wbs_sel_i),
    .wbs_adr_i   (wbs_adr_i),
    .wbs_dat_i   (wbs_dat_i),
    .wbs_ack_o   (wbs_ack_o),
    .wbs_dat_o   (wbs_dat_o),
    .cmd_val_o   (cmd_val),
    .cmd_rdy_i   (cmd_rdy),
    .cmd_data_o  (cmd_data),
    .opnd_val_o  (opnd_val),
    .opnd_rdy_i  (opnd_rdy),
    .opnd_data_o (opnd_data),
    .res_val_i   (res_val),
    .res_rdy_o   (res_rdy),
    .res_data_i  (res_data)
  );

  accel_join_stage join_inst (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .cmd_val_i   (cmd_val),
    .cmd_rdy_o   (cmd_rdy),
    .cmd_data_i  (cmd_data),
    .opnd_val_i  (opnd_val),
    .opnd_rdy_o  (opnd_rdy),
    .opnd_data_i (opnd_data),
    .j_val_o     (j_val),
    .j_rdy_i     (j_rdy),
    .j_op_o      (j_op),
    .j_opnd_o    (j_opnd)
  );

  accel_exec_stage exec_inst (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .j_val_i    (j_val),
    .j_rdy_o    (j_rdy),
    .j_op_i     (j_op),
    .j_opnd_i   (j_opnd),
    .res_val_o  (res_val),
    .res_rdy_i  (res_rdy),
    .res_data_o (res_data)
  );

endmodule

//--- logic/wb_stream_bridge.sv
// wishbone stream bridge
// maps input and output stream queues into the bus address space

`timescale 1ns/100ps
`include "wb_accel_macros.svh"

module wb_stream_bridge #(
  parameter int DEPTH = `QUEUE_DEPTH
) (
  input  logic                  clk,
  input  logic                  rst_n_i,
  // wishbone slave
  input  logic                  wbs_stb_i,
  input  logic                  wbs_cyc_i,
  input  logic                  wbs_we_i,
  input  logic [3:0]            wbs_sel_i,
  input  logic [31:0]           wbs_adr_i,
  input  logic [`WB_DATA_W-1:0] wbs_dat_i,
  output logic                  wbs_ack_o,
  output logic [`WB_DATA_W-1:0] wbs_dat_o,
  // command stream
  output logic                  cmd_val_o,
  input  logic                  cmd_rdy_i,
  output logic [`WB_DATA_W-1:0] cmd_data_o,
  // operand stream
  output logic                  opnd_val_o,
  input  logic                  opnd_rdy_i,
  output logic [`WB_DATA_W-1:0] opnd_data_o,
  // result stream
  input  logic                  res_val_i,
  output logic                  res_rdy_o,
  input  logic [`WB_DATA_W-1:0] res_data_i
);

  localparam logic [31:0] IN_BASE  = `ISTREAM_BASE;
  localparam logic [31:0] OUT_BASE = `OSTREAM_BASE;
  localparam logic [31:0] OUT_END  = `OSTREAM_BASE + 32'd8 * `NUM_OSTREAM;
  localparam int SLOT_W = (`NUM_ISTREAM > 1) ? $clog2(`NUM_ISTREAM) : 1;

  ////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////

  logic                     req;
  logic                     in_region;
  logic                     out_region;
  logic [31:0]              slot_off;
  logic [SLOT_W-1:0]        slot_idx;
  wb_accel_pkg::wb_access_e access;

  assign req        = wbs_stb_i && wbs_cyc_i;
  assign in_region  = (wbs_adr_i >= IN_BASE) && (wbs_adr_i < OUT_BASE);
  assign out_region = (wbs_adr_i >= OUT_BASE) && (wbs_adr_i < OUT_END);

  // 8 bytes per stream slot
  assign slot_off = wbs_adr_i - IN_BASE;
  assign slot_idx = slot_off[3 +: SLOT_W];

  // sel is ignored, every access is a full word
  always_comb begin
    access = wb_accel_pkg::ACC_NONE;
    if (req && in_region) begin
      if (!wbs_we_i && (wbs_adr_i[2:0] == 3'd0)) begin
        access = wb_accel_pkg::ACC_IN_STATUS;
      end else if (wbs_we_i && (wbs_adr_i[2:0] == 3'd4)) begin
        access = wb_accel_pkg::ACC_IN_WRITE;
      end
    end else if (req && out_region && !wbs_we_i) begin
      if (wbs_adr_i[2:0] == 3'd0) begin
        access = wb_accel_pkg::ACC_OUT_STATUS;
      end else if (wbs_adr_i[2:0] == 3'd4) begin
        access = wb_accel_pkg::ACC_OUT_READ;
      end
    end
  end

  // no wait states
  assign wbs_ack_o = req;

  ////////////////////////////////////////////////////////////
  // input stream queues
  ////////////////////////////////////////////////////////////

  logic                  in_enq_val  [`NUM_ISTREAM];
  logic                  in_enq_rdy  [`NUM_ISTREAM];
  logic                  in_deq_val  [`NUM_ISTREAM];
  logic                  in_deq_rdy  [`NUM_ISTREAM];
  logic [`WB_DATA_W-1:0] in_deq_data [`NUM_ISTREAM];

  for (genvar g = 0; g < `NUM_ISTREAM; g++) begin : g_in_queue
    // full queue drops the write
    assign in_enq_val[g] = (access == wb_accel_pkg::ACC_IN_WRITE) && (slot_idx == SLOT_W'(g));

    stream_queue #(
      .DEPTH (DEPTH),
      .WIDTH (`WB_DATA_W)
    ) in_queue (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .enq_val_i  (in_enq_val[g]),
      .enq_rdy_o  (in_enq_rdy[g]),
      .enq_data_i (wbs_dat_i),
      .deq_val_o  (in_deq_val[g]),
      .deq_rdy_i  (in_deq_rdy[g]),
      .deq_data_o (in_deq_data[g]),
      .num_free_o ()
    );
  end

  // stream 0 commands, stream 1 operands
  assign cmd_val_o     = in_deq_val[0];
  assign cmd_data_o    = in_deq_data[0];
  assign in_deq_rdy[0] = cmd_rdy_i;
  assign opnd_val_o    = in_deq_val[1];
  assign opnd_data_o   = in_deq_data[1];
  assign in_deq_rdy[1] = opnd_rdy_i;

  ////////////////////////////////////////////////////////////
  // output stream queue
  ////////////////////////////////////////////////////////////

  logic                  out_deq_val;
  logic                  out_pop;
  logic [`WB_DATA_W-1:0] out_deq_data;

  // a data read pops the head
  assign out_pop = (access == wb_accel_pkg::ACC_OUT_READ);

  stream_queue #(
    .DEPTH (DEPTH),
    .WIDTH (`WB_DATA_W)
  ) out_queue (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .enq_val_i  (res_val_i),
    .enq_rdy_o  (res_rdy_o),
    .enq_data_i (res_data_i),
    .deq_val_o  (out_deq_val),
    .deq_rdy_i  (out_pop),
    .deq_data_o (out_deq_data),
    .num_free_o ()
  );

  ////////////////////////////////////////////////////////////
  // read data
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (access)
      wb_accel_pkg::ACC_IN_STATUS:
        wbs_dat_o = {{(`WB_DATA_W-1){1'b0}}, in_enq_rdy[slot_idx]};
      wb_accel_pkg::ACC_OUT_STATUS:
        wbs_dat_o = {{(`WB_DATA_W-1){1'b0}}, out_deq_val};
      // empty queue reads as zero
      wb_accel_pkg::ACC_OUT_READ:
        wbs_dat_o = out_deq_val ? out_deq_data : '0;
      default:
        wbs_dat_o = '0;
    endcase
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the accelerator testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal \
  -f wb_accel_top.f \
  --top-module tb_wb_accel_top \
  -o tb_wb_accel_top
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_wb_accel_top > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "sim failed" "$LOG"; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
exit 0

//--- sim/tb_wb_accel_top.sv
// testbench for the accumulator accelerator
// directed bus tests against a reference model of the accumulator

`timescale 1ns/100ps
`include "wb_accel_macros.svh"

module tb_wb_accel_top;

  localparam logic [31:0] CMD_STATUS  = `ISTREAM_BASE;
  localparam logic [31:0] CMD_DATA    = `ISTREAM_BASE + 32'd4;
  localparam logic [31:0] OPND_STATUS = `ISTREAM_BASE + 32'd8;
  localparam logic [31:0] OPND_DATA   = `ISTREAM_BASE + 32'd12;
  localparam logic [31:0] RES_STATUS  = `OSTREAM_BASE;
  localparam logic [31:0] RES_DATA    = `OSTREAM_BASE + 32'd4;
  // each access takes 2 cycles, budget 8 per planned access
  localparam int PLANNED_ACCESSES = 330;
  localparam int TIMEOUT_NS = PLANNED_ACCESSES * 8 * 8 + 5000;

  logic                  clk;
  logic                  rst_n_i;
  logic                  wbs_stb_i;
  logic                  wbs_cyc_i;
  logic                  wbs_we_i;
  logic [3:0]            wbs_sel_i;
  logic [31:0]           wbs_adr_i;
  logic [`WB_DATA_W-1:0] wbs_dat_i;
  logic                  wbs_ack_o;
  logic [`WB_DATA_W-1:0] wbs_dat_o;

  integer                seed = 67196;
  logic [`WB_DATA_W-1:0] model_acc;
  logic [`WB_DATA_W-1:0] exp_results [$];

  wb_accel_top wb_accel_top_inst (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .wbs_stb_i (wbs_stb_i),
    .wbs_cyc_i (wbs_cyc_i),
    .wbs_we_i  (wbs_we_i),
    .wbs_sel_i (wbs_sel_i),
    .wbs_adr_i (wbs_adr_i),
    .wbs_dat_i (wbs_dat_i),
    .wbs_ack_o (wbs_ack_o),
    .wbs_dat_o (wbs_dat_o)
  );

  always #4 clk = ~clk;

  initial begin
    #(TIMEOUT_NS);
    stop_with_failure("watchdog expired, the tests did not finish in time");
  end

  ////////////////////////////////////////////////////////////
  // reporting and compare tasks
  ////////////////////////////////////////////////////////////

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("sim failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_word(input string name, input logic [`WB_DATA_W-1:0] exp,
                            input logic [`WB_DATA_W-1:0] act);
    if (act !== exp) begin
      stop_with_failure($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_with_failure($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_op(input string name, input wb_accel_pkg::accel_op_e exp,
                          input wb_accel_pkg::accel_op_e act);
    if (act !== exp) begin
      stop_with_failure($sformatf("Fail %s: expected %s, actual %s", name, exp.name(),
                                  act.name()));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [`WB_DATA_W-1:0] apply_op(input wb_accel_pkg::accel_op_e op,
      input logic [`WB_DATA_W-1:0] acc, input logic [`WB_DATA_W-1:0] opnd);
    case (op)
      wb_accel_pkg::OP_LOAD: return opnd;
      wb_accel_pkg::OP_ADD:  return acc + opnd;
      wb_accel_pkg::OP_XOR:  return acc ^ opnd;
      default:               return acc * opnd;
    endcase
  endfunction

  // which opcode turns prev into result with this operand
  function automatic wb_accel_pkg::accel_op_e infer_op(input logic [`WB_DATA_W-1:0] prev,
      input logic [`WB_DATA_W-1:0] opnd, input logic [`WB_DATA_W-1:0] result);
    wb_accel_pkg::accel_op_e op;
    op = wb_accel_pkg::OP_LOAD;
    for (int k = 3; k >= 0; k--) begin
      if (apply_op(wb_accel_pkg::accel_op_e'(k[1:0]), prev, opnd) == result) begin
        op = wb_accel_pkg::accel_op_e'(k[1:0]);
      end
    end
    return op;
  endfunction

  task automatic model_push(input logic [`WB_DATA_W-1:0] cmd, input logic [`WB_DATA_W-1:0] opnd);
    model_acc = apply_op(wb_accel_pkg::accel_op_e'(cmd[1:0]), model_acc, opnd);
    exp_results.push_back(model_acc);
  endtask

  ////////////////////////////////////////////////////////////
  // bus driver
  ////////////////////////////////////////////////////////////

  task automatic bus_cycle(input logic we, input logic [31:0] adr,
                           input logic [`WB_DATA_W-1:0] wdata,
                           output logic [`WB_DATA_W-1:0] rdata);
    @(negedge clk);
    wbs_stb_i = 1'b1;
    wbs_cyc_i = 1'b1;
    wbs_we_i  = we;
    wbs_adr_i = adr;
    wbs_dat_i = wdata;
    // read data settles well before the rising edge
    #2;
    if (wbs_ack_o !== 1'b1) begin
      stop_with_failure($sformatf("no acknowledge for access to address %h", adr));
    end
    rdata = wbs_dat_o;
    @(posedge clk);
    @(negedge clk);
    wbs_stb_i = 1'b0;
    wbs_cyc_i = 1'b0;
    wbs_we_i  = 1'b0;
  endtask

  task automatic wb_write(input logic [31:0] adr, input logic [`WB_DATA_W-1:0] data);
    logic [`WB_DATA_W-1:0] unused;
    bus_cycle(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input logic [31:0] adr, output logic [`WB_DATA_W-1:0] data);
    bus_cycle(1'b0, adr, '0, data);
  endtask

  task automatic read_flag(input logic [31:0] adr, output logic flag);
    logic [`WB_DATA_W-1:0] word;
    wb_read(adr, word);
    flag = word[0];
  endtask

  task automatic push_pair(input logic [`WB_DATA_W-1:0] cmd, input logic [`WB_DATA_W-1:0] opnd);
    wb_write(CMD_DATA, cmd);
    wb_write(OPND_DATA, opnd);
    model_push(cmd, opnd);
  endtask

  // poll the output status until a result is waiting
  task automatic wait_for_result(input string name);
    logic flag;
    int   polls;
    flag  = 1'b0;
    polls = 0;
    while (!flag) begin
      if (polls == 64) begin
        stop_with_failure($sformatf("%s: no result appeared on the output stream", name));
      end
      read_flag(RES_STATUS, flag);
      polls++;
    end
  endtask

  // wait for one result, then pop it and compare
  task automatic pop_and_check(input string name, output logic [`WB_DATA_W-1:0] act);
    wait_for_result(name);
    wb_read(RES_DATA, act);
    check_word(name, exp_results.pop_front(), act);
  endtask

  task automatic drain_and_check(input string name);
    logic [`WB_DATA_W-1:0] act;
    while (exp_results.size() > 0) begin
      pop_and_check(name, act);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    logic [`WB_DATA_W-1:0] word;
    wb_read(CMD_STATUS, word);
    check_word("reset cmd status", 32'd1, word);
    wb_read(OPND_STATUS, word);
    check_word("reset opnd status", 32'd1, word);
    wb_read(RES_STATUS, word);
    check_word("reset res status", 32'd0, word);
    wb_read(RES_DATA, word);
    check_word("reset res data", 32'd0, word);
  endtask

  task automatic test_each_opcode();
    // operands picked so that all four opcodes give distinct results
    logic [`WB_DATA_W-1:0] opnds [4] = '{32'h0A5F, 32'h1237, 32'h0F0F, 32'h7};
    logic [`WB_DATA_W-1:0] prev;
    logic [`WB_DATA_W-1:0] act;
    logic [`WB_DATA_W-1:0] r;
    push_pair(32'h0000_0000, 32'h13);
    pop_and_check("opcode seed", act);
    for (int k = 0; k < 4; k++) begin
      r    = $random(seed);
      prev = model_acc;
      push_pair({r[31:2], k[1:0]}, opnds[k]);
      wait_for_result("opcode result");
      wb_read(RES_DATA, act);
      check_op("opcode applied", wb_accel_pkg::accel_op_e'(k[1:0]),
               infer_op(prev, opnds[k], act));
      check_word("opcode result", exp_results.pop_front(), act);
    end
  endtask

  task automatic test_random_pairs();
    for (int grp = 0; grp < 6; grp++) begin
      // five pairs in flight, then drain
      for (int k = 0; k < 5; k++) begin
        push_pair($random(seed), $random(seed));
      end
      drain_and_check("random pairs");
    end
  endtask

  task automatic test_commands_only();
    logic [`WB_DATA_W-1:0] cmds [$];
    logic                  flag;
    read_flag(CMD_STATUS, flag);
    while (flag && cmds.size() < 16) begin
      cmds.push_back($random(seed));
      wb_write(CMD_DATA, cmds[cmds.size()-1]);
      read_flag(CMD_STATUS, flag);
    end
    check_word("commands accepted", `QUEUE_DEPTH, cmds.size());
    read_flag(RES_STATUS, flag);
    check_flag("no result without operands", 1'b0, flag);
    foreach (cmds[i]) begin
      wb_write(OPND_DATA, 32'h100 + i);
      model_push(cmds[i], 32'h100 + i);
    end
    drain_and_check("commands only");
  endtask

  task automatic test_back_pressure();
    logic cmd_rdy;
    logic opnd_rdy;
    logic stalled;
    int   accepted;
    stalled  = 1'b0;
    accepted = 0;
    while (!stalled && accepted < 16) begin
      read_flag(CMD_STATUS, cmd_rdy);
      read_flag(OPND_STATUS, opnd_rdy);
      if (cmd_rdy && opnd_rdy) begin
        push_pair($random(seed), $random(seed));
        accepted++;
      end else begin
        stalled = 1'b1;
      end
    end
    check_flag("input stalled", 1'b1, stalled);
    // output queue, both stage registers and both input queues
    check_word("pairs accepted", 2 * `QUEUE_DEPTH + 2, accepted);
    for (int k = 0; k < 3; k++) begin
      wb_write(CMD_DATA, 32'hDEAD_BEE0 + k);
      wb_write(OPND_DATA, 32'hCAFE_0000 + k);
    end
    read_flag(CMD_STATUS, cmd_rdy);
    check_flag("cmd still full", 1'b0, cmd_rdy);
    drain_and_check("back pressure");
    read_flag(RES_STATUS, stalled);
    check_flag("dropped writes gave no result", 1'b0, stalled);
  endtask

  task automatic test_unmapped();
    logic [`WB_DATA_W-1:0] word;
    wb_read(CMD_DATA, word);
    check_word("read of input data", 32'd0, word);
    wb_read(OPND_DATA, word);
    check_word("read of operand data", 32'd0, word);
    wb_read(`ISTREAM_BASE + 32'd2, word);
    check_word("misaligned read", 32'd0, word);
    wb_read(`OSTREAM_BASE + 32'd8, word);
    check_word("read past output stream", 32'd0, word);
    wb_read(32'h2000_0000, word);
    check_word("read below input stream", 32'd0, word);
    wb_write(CMD_STATUS, 32'h3);
    wb_write(OPND_STATUS, 32'h55);
    wb_write(RES_STATUS, 32'h1);
    wb_write(RES_DATA, 32'h77);
    wb_write(32'h2000_0004, 32'h99);
    wb_read(RES_STATUS, word);
    check_word("res status after stray writes", 32'd0, word);
    push_pair(32'h0000_0001, 32'h0000_1000);
    drain_and_check("after unmapped accesses");
  endtask

  initial begin
    clk       = 1'b0;
    rst_n_i   = 1'b0;
    wbs_stb_i = 1'b0;
    wbs_cyc_i = 1'b0;
    wbs_we_i  = 1'b0;
    wbs_sel_i = 4'hF;
    wbs_adr_i = '0;
    wbs_dat_i = '0;
    model_acc = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;
    test_reset_state();
    test_each_opcode();
    test_random_pairs();
    test_commands_only();
    test_back_pressure();
    test_unmapped();
    $display("sim passed");
    $finish;
  end

endmodule

//--- wb_accel_top.f
+incdir+include
logic/wb_accel_pkg.sv
logic/stream_queue.sv
logic/wb_stream_bridge.sv
logic/accel_join_stage.sv
logic/accel_exec_stage.sv
logic/wb_accel_top.sv
sim/tb_wb_accel_top.sv
